/* rtl/lmfe_pkg.sv */
// shared constants and packed types for the sliding-window median filter, referenced by scope
package lmfe_pkg;

  // sample format
  localparam int SAMPLE_W = 8;

  // window length, must stay odd so one middle rank exists
  localparam int WIN = 49;

  // rank of the median, counted from the smallest cell
  localparam int MED_IDX = (WIN - 1) / 2;

  // ring pointer and fill counter width, enough to hold WIN
  localparam int PTR_W = 6;

  // last ring slot before the pointer wraps
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(WIN - 1);

  // fill count at which the window holds only real samples
  localparam logic [PTR_W-1:0] FILL_DONE = PTR_W'(WIN);

  typedef logic [SAMPLE_W-1:0] sample_t;

  // every ring slot and rank cell starts here after reset
  localparam sample_t FILL_VALUE = 8'hff;

  // one insert/delete request for the rank chain
  // ins == del means no change in any cell
  typedef struct packed {
    logic    valid;
    sample_t ins;
    sample_t del;
  } sort_op_t;

  // median tap of the chain
  typedef struct packed {
    logic    valid;
    sample_t value;
  } median_t;

endpackage

/* rtl/sample_window.sv */
// input side of the median filter, turns each accepted sample into an insert/delete operation
`timescale 1ns/1ps

module sample_window (
  input  logic                CLK,
  input  logic                RST,
  input  logic                in_en,
  input  lmfe_pkg::sample_t   din,
  output lmfe_pkg::sort_op_t  op
);

  // history of the last WIN samples, oldest entry sits at wr_ptr
  lmfe_pkg::sample_t ring [lmfe_pkg::WIN];

  logic [lmfe_pkg::PTR_W-1:0] wr_ptr;
  logic [lmfe_pkg::PTR_W-1:0] wr_ptr_nxt;

  // wrap at WIN, not at the power of two
  always_comb begin
    if (wr_ptr == lmfe_pkg::PTR_LAST) begin
      wr_ptr_nxt = '0;
    end else begin
      wr_ptr_nxt = wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      for (int i = 0; i < lmfe_pkg::WIN; i++) begin
        ring[i] <= lmfe_pkg::FILL_VALUE;
      end
    end else if (in_en) begin
      ring[wr_ptr] <= din;
      wr_ptr       <= wr_ptr_nxt;
    end
  end

  // the op leaves one edge after the sample, the overwritten entry is the one to delete
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op.valid <= 1'b0;
      op.ins   <= lmfe_pkg::FILL_VALUE;
      op.del   <= lmfe_pkg::FILL_VALUE;
    end else begin
      op.valid <= in_en;
      if (in_en) begin
        op.ins <= din;
        op.del <= ring[wr_ptr];
      end
    end
  end

  // pointer must never address past the ring
  a_ptr_in_range: assert property (
    @(posedge CLK) disable iff (RST)
    wr_ptr <= lmfe_pkg::PTR_LAST
  ) else $error("sample_window pointer out of range: %0d", wr_ptr);

endmodule

/* rtl/rank_cell.sv */
// one ordered cell of the rank chain, updated by an insert/delete pair each valid cycle
`timescale 1ns/1ps

module rank_cell (
  input  logic                CLK,
  input  logic                RST,
  input  lmfe_pkg::sort_op_t  op,
  input  lmfe_pkg::sample_t   prev,
  input  lmfe_pkg::sample_t   next,
  output lmfe_pkg::sample_t   value
);

  lmfe_pkg::sample_t value_nxt;

  always_comb begin
    value_nxt = value;
    if (op.ins < op.del) begin
      // smaller value comes in, cells in (ins, del] shift up by one rank
      if (value > op.ins && value <= op.del) begin
        value_nxt = (prev > op.ins) ? prev : op.ins;
      end
    end else if (op.ins > op.del) begin
      // larger value comes in, cells in [del, ins) shift down by one rank
      if (value < op.ins && value >= op.del) begin
        value_nxt = (next < op.ins) ? next : op.ins;
      end
    end
    // equal ins and del keeps the chain as it is
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      value <= lmfe_pkg::FILL_VALUE;
    end else begin
      value <= value_nxt;
    end
  end

endmodule

/* rtl/rank_array.sv */
// processing part of the median filter, a chain of WIN rank cells with the median tap
`timescale 1ns/1ps

module rank_array (
  input  logic                CLK,
  input  logic                RST,
  input  lmfe_pkg::sort_op_t  op,
  output lmfe_pkg::median_t   median
);

  // cell outputs, index 0 holds the smallest value
  lmfe_pkg::sample_t cell_val [lmfe_pkg::WIN];

  lmfe_pkg::sort_op_t cell_op;
  logic               med_valid;

  // idle cycles present ins == del so no cell moves
  always_comb begin
    cell_op.valid = op.valid;
    cell_op.del   = op.del;
    cell_op.ins   = op.valid ? op.ins : op.del;
  end

  for (genvar i = 0; i < lmfe_pkg::WIN; i++) begin : g_cell
    lmfe_pkg::sample_t prev_val;
    lmfe_pkg::sample_t next_val;

    // chain ends see the extremes of the sample range
    if (i == 0) begin : g_low
      assign prev_val = '0;
    end else begin : g_mid_low
      assign prev_val = cell_val[i-1];
    end

    if (i == lmfe_pkg::WIN - 1) begin : g_high
      assign next_val = lmfe_pkg::FILL_VALUE;
    end else begin : g_mid_high
      assign next_val = cell_val[i+1];
    end

    rank_cell u_cell (
      .CLK   (CLK),
      .RST   (RST),
      .op    (cell_op),
      .prev  (prev_val),
      .next  (next_val),
      .value (cell_val[i])
    );

    // the chain stays sorted across every insert/delete
    if (i > 0) begin : g_order
      a_sorted: assert property (
        @(posedge CLK) disable iff (RST)
        cell_val[i-1] <= cell_val[i]
      ) else $error("rank chain out of order at cell %0d", i);
    end
  end

  // cells settle at the same edge, so the flag just follows the op by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      med_valid <= 1'b0;
    end else begin
      med_valid <= op.valid;
    end
  end

  assign median.valid = med_valid;
  assign median.value = cell_val[lmfe_pkg::MED_IDX];

endmodule

/* rtl/median_out.sv */
// output side of the median filter, holds results back until the window is filled with samples
`timescale 1ns/1ps

module median_out (
  input  logic               CLK,
  input  logic               RST,
  input  lmfe_pkg::median_t  median,
  output logic               out_valid,
  output lmfe_pkg::sample_t  dout
);

  // number of valid medians seen, stops at WIN
  logic [lmfe_pkg::PTR_W-1:0] fill_cnt;
  logic                       fill_last;

  // the WIN-th median is the first one without reset filler in it
  assign fill_last = (fill_cnt >= lmfe_pkg::FILL_DONE - 1'b1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      fill_cnt <= '0;
    end else if (median.valid && fill_cnt != lmfe_pkg::FILL_DONE) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
      dout      <= '0;
    end else begin
      out_valid <= median.valid && fill_last;
      if (median.valid && fill_last) begin
        dout <= median.value;
      end
    end
  end

  // no result escapes before the window is full
  a_no_early_valid: assert property (
    @(posedge CLK) disable iff (RST)
    out_valid |-> (fill_cnt == lmfe_pkg::FILL_DONE)
  ) else $error("out_valid raised with fill count %0d", fill_cnt);

endmodule

/* rtl/median_filter_top.sv */
// top level of the streaming median filter, one sample per in_en strobe, result two edges later
`timescale 1ns/1ps

module median_filter_top (
  input  logic               CLK,
  input  logic               RST,
  input  logic               in_en,
  input  lmfe_pkg::sample_t  din,
  output logic               out_valid,
  output lmfe_pkg::sample_t  dout
);

  lmfe_pkg::sort_op_t sort_op;
  lmfe_pkg::median_t  median;

  // sample history, produces the insert/delete pair
  sample_window u_window (
    .CLK   (CLK),
    .RST   (RST),
    .in_en (in_en),
    .din   (din),
    .op    (sort_op)
  );

  // ordered chain, median read from the middle cell
  rank_array u_rank (
    .CLK    (CLK),
    .RST    (RST),
    .op     (sort_op),
    .median (median)
  );

  median_out u_out (
    .CLK       (CLK),
    .RST       (RST),
    .median    (median),
    .out_valid (out_valid),
    .dout      (dout)
  );

endmodule

/* test/median_filter_tb.sv */
// table-driven testbench for median_filter_top, checks every median against a sorted window model
`timescale 1ns/1ps

module median_filter_tb;

  typedef enum logic [2:0] {PAT_RANDOM, PAT_CONST, PAT_ASC, PAT_DESC, PAT_EXTREME} pat_t;

  typedef struct packed {
    pat_t kind;
    int   count;
    int   gap;
  } row_t;

  // expected median and the cycle count at which it must show up
  typedef struct packed {
    lmfe_pkg::sample_t value;
    int                due;
  } expect_t;

  localparam int NUM_ROWS = 8;

  // kind, sample count, idle cycles between samples
  row_t stim_rows [NUM_ROWS] = '{
    '{PAT_RANDOM,  60, 0},
    '{PAT_RANDOM,  40, 3},
    '{PAT_CONST,   60, 0},
    '{PAT_ASC,     80, 0},
    '{PAT_DESC,    80, 1},
    '{PAT_EXTREME, 70, 0},
    '{PAT_CONST,   30, 2},
    '{PAT_RANDOM,  50, 0}
  };

  logic              CLK;
  logic              RST;
  logic              in_en;
  lmfe_pkg::sample_t din;
  logic              out_valid;
  lmfe_pkg::sample_t dout;

  lmfe_pkg::sample_t window_q [$];
  expect_t           exp_q [$];
  expect_t           got_e;
  int                cycle_cnt;
  int                err_cnt;
  int                out_cnt;
  int                accepted;

  median_filter_top uut (
    .CLK       (CLK),
    .RST       (RST),
    .in_en     (in_en),
    .din       (din),
    .out_valid (out_valid),
    .dout      (dout)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt++;
  end

  task automatic check_sample(input string name, input lmfe_pkg::sample_t got,
                              input lmfe_pkg::sample_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // rank MED_IDX of the current window, by insertion sort on a copy
  function automatic lmfe_pkg::sample_t model_median();
    lmfe_pkg::sample_t srt [lmfe_pkg::WIN];
    lmfe_pkg::sample_t key;
    int j;
    foreach (window_q[i]) begin
      srt[i] = window_q[i];
    end
    for (int i = 1; i < lmfe_pkg::WIN; i++) begin
      key = srt[i];
      j = i - 1;
      while (j >= 0 && srt[j] > key) begin
        srt[j+1] = srt[j];
        j--;
      end
      srt[j+1] = key;
    end
    return srt[lmfe_pkg::MED_IDX];
  endfunction

  function automatic lmfe_pkg::sample_t next_sample(input pat_t kind, input int idx);
    case (kind)
      PAT_CONST:   return 8'h5a;
      PAT_ASC:     return 8'(idx * 3);
      PAT_DESC:    return 8'(255 - idx * 2);
      PAT_EXTREME: return ($urandom % 2) ? 8'hff : 8'h00;
      default:     return 8'($urandom);
    endcase
  endfunction

  // samples plus gaps, a drain allowance per row, reset and margin
  function automatic int run_cycles();
    int total;
    total = 3 + 20;
    foreach (stim_rows[r]) begin
      total += stim_rows[r].count * (stim_rows[r].gap + 1) + 8;
    end
    return total + 200;
  endfunction

  // one strobe, the model and scoreboard follow the same sample
  task automatic drive_sample(input lmfe_pkg::sample_t s);
    in_en = 1'b1;
    din   = s;
    void'(window_q.pop_front());
    window_q.push_back(s);
    accepted++;
    // sampled at the next edge, result visible after two more edges
    if (accepted >= lmfe_pkg::WIN) begin
      exp_q.push_back('{value: model_median(), due: cycle_cnt + 3});
    end
    @(negedge CLK);
    in_en = 1'b0;
  endtask

  // outputs are read at the falling edge
  always @(negedge CLK) begin
    if (!RST && out_valid) begin
      out_cnt++;
      if (exp_q.size() == 0) begin
        $display("out_valid high at cycle %0d while no result was expected", cycle_cnt);
        err_cnt++;
      end else begin
        got_e = exp_q.pop_front();
        check_sample("dout", dout, got_e.value);
        if (cycle_cnt != got_e.due) begin
          $display("result arrived at cycle %0d instead of cycle %0d", cycle_cnt, got_e.due);
          err_cnt++;
        end
      end
    end
  end

  initial begin
    repeat (run_cycles()) @(posedge CLK);
    $display("timeout, the run did not finish within %0d cycles", run_cycles());
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int row_err;
    RST       = 1'b1;
    in_en     = 1'b0;
    din       = '0;
    cycle_cnt = 0;
    err_cnt   = 0;
    out_cnt   = 0;
    accepted  = 0;
    void'($urandom(55));
    for (int i = 0; i < lmfe_pkg::WIN; i++) begin
      window_q.push_back(lmfe_pkg::FILL_VALUE);
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    // output register comes out of reset cleared
    check_sample("dout", dout, '0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      row_err = err_cnt;
      for (int k = 0; k < stim_rows[r].count; k++) begin
        drive_sample(next_sample(stim_rows[r].kind, k));
        repeat (stim_rows[r].gap) @(negedge CLK);
      end
      // drain the pipeline, then a few idle cycles to catch stray strobes
      while (exp_q.size() != 0) begin
        @(negedge CLK);
      end
      repeat (3) @(negedge CLK);
      $display("row %0d %s: %0d samples, gap %0d, %0d errors", r, stim_rows[r].kind.name(),
               stim_rows[r].count, stim_rows[r].gap, err_cnt - row_err);
    end

    check_count("out_valid pulses", out_cnt, accepted - (lmfe_pkg::WIN - 1));
    $display("samples %0d, outputs %0d, errors %0d", accepted, out_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
rtl/lmfe_pkg.sv
rtl/sample_window.sv
rtl/rank_cell.sv
rtl/rank_array.sv
rtl/median_out.sv
rtl/median_filter_top.sv
test/median_filter_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the median filter testbench with Verilator
# the run fails when the log holds the fail message

LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --assert -f vlog.f \
  --top-module median_filter_tb -o median_filter_sim > "$LOG" 2>&1 &&
  ./obj_dir/median_filter_sim >> "$LOG" 2>&1 ||
  echo "CHECKS FAILED" >> "$LOG"

cat "$LOG"

grep -q "CHECKS FAILED" "$LOG" && exit 1 || exit 0
